//--- aes_apb_adapter.sv
`timescale 1ns/1ps
`include "aes_reg_params.svh"

module aes_apb_adapter (
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  logic [`AES_REG_APB_AW-1:0] paddr_i,
  input  aes_reg_pkg::word_t         pwdata_i,
  output aes_reg_pkg::word_t         prdata_o,
  output logic                       pslverr_o,
  output logic                       pready_o,

  aes_reg_bus_if.adapter             bus
);

  logic access;

  // Only the access phase counts, setup phase is ignored
  assign access = psel_i & penable_i;

  assign bus.we = access & pwrite_i;
  assign bus.re = access & ~pwrite_i;

  // Only the low address bits are decoded
  assign bus.addr  = paddr_i[`AES_REG_AW-1:0];
  assign bus.wdata = pwdata_i;

  // Read data and error come back in the same cycle
  assign prdata_o  = bus.rdata;
  assign pslverr_o = bus.error;

  // No wait states
  assign pready_o = 1'b1;

endmodule

//--- aes_ctrl_readback.sv
`timescale 1ns/1ps
`include "aes_reg_params.svh"

module aes_ctrl_readback (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,

  aes_reg_bus_if.readback                           bus,
  input  logic [`AES_NUM_BANKS-1:0]                 bank_hit_i,

  input  aes_reg_pkg::word_t [`AES_BANK_WORDS-1:0]  data_out_i,
  output logic               [`AES_BANK_WORDS-1:0]  data_out_re_o,
  input  aes_reg_pkg::status_fields_t               status_i,

  output aes_reg_pkg::ctrl_fields_t                 ctrl_o,
  output logic                                      ctrl_aux_o,

  output logic                                      trigger_start_o,
  input  logic                                      trigger_start_ack_i,
  output logic                                      trigger_key_iv_data_in_clear_o,
  input  logic                                      trigger_key_iv_data_in_clear_ack_i,
  output logic                                      trigger_data_out_clear_o,
  input  logic                                      trigger_data_out_clear_ack_i
);

  localparam int AW = `AES_REG_AW;

  logic [`AES_BANK_WORDS-1:0]  dout_hit;
  logic                        ctrl_hit, aux_hit, regwen_hit, trig_hit, status_hit;
  logic                        addr_hit;
  aes_reg_pkg::reg_word_u      wd_u;
  aes_reg_pkg::ctrl_fields_t   ctrl_d, ctrl_q;
  aes_reg_pkg::status_fields_t status_d, status_q;
  logic                        aux_q, regwen_q;
  logic [2:0]                  trig_set, trig_ack, trig_q;
  aes_reg_pkg::word_t          rdata;

  // Own register decode
  always_comb begin
    for (int i = 0; i < `AES_BANK_WORDS; i++) begin
      dout_hit[i] = (bus.addr == AW'(`AES_DATA_OUT_OFFSET + 4 * i));
    end
  end

  assign ctrl_hit   = (bus.addr == `AES_CTRL_OFFSET);
  assign aux_hit    = (bus.addr == `AES_CTRL_AUX_OFFSET);
  assign regwen_hit = (bus.addr == `AES_CTRL_AUX_REGWEN_OFFSET);
  assign trig_hit   = (bus.addr == `AES_TRIGGER_OFFSET);
  assign status_hit = (bus.addr == `AES_STATUS_OFFSET);

  assign addr_hit = (|bank_hit_i) | (|dout_hit) | ctrl_hit | aux_hit | regwen_hit |
                    trig_hit | status_hit;

  // Miss only flagged during an access
  assign bus.error = (bus.we | bus.re) & ~addr_hit;

  assign data_out_re_o = dout_hit & {`AES_BANK_WORDS{bus.re}};

  assign wd_u.word = bus.wdata;

  // Keep only the implemented ctrl fields
  always_comb begin
    ctrl_d                  = '0;
    ctrl_d.operation        = wd_u.ctrl.operation;
    ctrl_d.mode             = wd_u.ctrl.mode;
    ctrl_d.key_len          = wd_u.ctrl.key_len;
    ctrl_d.manual_operation = wd_u.ctrl.manual_operation;
  end

  always_comb begin
    status_d              = '0;
    status_d.idle         = status_i.idle;
    status_d.stall        = status_i.stall;
    status_d.output_lost  = status_i.output_lost;
    status_d.output_valid = status_i.output_valid;
    status_d.input_ready  = status_i.input_ready;
  end

  // Software sets trigger bits, only the acknowledge clears them
  assign trig_set = {wd_u.trigger.data_out_clear, wd_u.trigger.key_iv_data_in_clear,
                     wd_u.trigger.start} & {3{bus.we & trig_hit}};
  assign trig_ack = {trigger_data_out_clear_ack_i, trigger_key_iv_data_in_clear_ack_i,
                     trigger_start_ack_i};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q   <= '0;
      aux_q    <= `AES_CTRL_AUX_RESVAL;
      regwen_q <= `AES_REGWEN_RESVAL;
      trig_q   <= `AES_TRIGGER_RESVAL;
      status_q <= '0;
    end else begin
      if (bus.we && ctrl_hit) begin
        ctrl_q <= ctrl_d;
      end
      // Aux bit is frozen once the lock is closed
      if (bus.we && aux_hit && regwen_q) begin
        aux_q <= bus.wdata[0];
      end
      // Write 0 to clear, a 1 has no effect
      if (bus.we && regwen_hit && !bus.wdata[0]) begin
        regwen_q <= 1'b0;
      end
      // A set in the same cycle as an ack wins
      trig_q   <= (trig_q & ~trig_ack) | trig_set;
      status_q <= status_d;
    end
  end

  // Read mux, write-only words read as zero
  always_comb begin
    rdata = '0;
    for (int i = 0; i < `AES_BANK_WORDS; i++) begin
      if (dout_hit[i]) begin
        rdata = data_out_i[i];
      end
    end
    if (ctrl_hit) begin
      rdata = ctrl_q;
    end
    if (aux_hit) begin
      rdata[0] = aux_q;
    end
    if (regwen_hit) begin
      rdata[0] = regwen_q;
    end
    if (status_hit) begin
      rdata = status_q;
    end
    if (!addr_hit) begin
      rdata = '1;
    end
  end

  assign bus.rdata = rdata;

  assign ctrl_o                         = ctrl_q;
  assign ctrl_aux_o                     = aux_q;
  assign trigger_start_o                = trig_q[0];
  assign trigger_key_iv_data_in_clear_o = trig_q[1];
  assign trigger_data_out_clear_o       = trig_q[2];

endmodule

//--- aes_reg_bus_if.sv
`timescale 1ns/1ps
`include "aes_reg_params.svh"

interface aes_reg_bus_if;

  logic                   we;
  logic                   re;
  logic [`AES_REG_AW-1:0] addr;
  aes_reg_pkg::word_t     wdata;
  aes_reg_pkg::word_t     rdata;
  logic                   error;

  modport adapter (output we, re, addr, wdata, input rdata, error);

  // Banks are write-only, so no read strobe
  modport bank (input we, addr, wdata);

  modport readback (input we, re, addr, wdata, output rdata, error);

endinterface

//--- aes_reg_params.svh
`ifndef AES_REG_PARAMS_SVH
`define AES_REG_PARAMS_SVH

// Bus and decode widths
`define AES_REG_DW      32
`define AES_REG_AW      8
`define AES_REG_APB_AW  12

// Write-only word banks, contiguous and 16 bytes apart
`define AES_BANK_WORDS  4
`define AES_NUM_BANKS   6
`define AES_BANK_BASE   8'h04

// Remaining register offsets
`define AES_DATA_OUT_OFFSET         8'h64
`define AES_CTRL_OFFSET             8'h78
`define AES_CTRL_AUX_OFFSET         8'h7C
`define AES_CTRL_AUX_REGWEN_OFFSET  8'h80
`define AES_TRIGGER_OFFSET          8'h84
`define AES_STATUS_OFFSET           8'h88

// Reset values
`define AES_CTRL_AUX_RESVAL  1'b1
`define AES_REGWEN_RESVAL    1'b1
// Order is {data_out_clear, key_iv_data_in_clear, start}
`define AES_TRIGGER_RESVAL   3'b110

`endif

//--- aes_reg_pkg.sv
`include "aes_reg_params.svh"

package aes_reg_pkg;

  typedef logic [`AES_REG_DW-1:0] word_t;

  // Control register, bit positions as in the full AES register map
  typedef struct packed {
    logic [15:0] pad_hi;
    logic        manual_operation;
    // Former reseed rate and sideload bits
    logic [3:0]  pad_mid;
    logic [2:0]  key_len;
    logic [5:0]  mode;
    logic [1:0]  operation;
  } ctrl_fields_t;

  typedef struct packed {
    logic [28:0] pad;
    logic        data_out_clear;
    logic        key_iv_data_in_clear;
    logic        start;
  } trigger_fields_t;

  typedef struct packed {
    logic [26:0] pad;
    logic        input_ready;
    logic        output_valid;
    logic        output_lost;
    logic        stall;
    logic        idle;
  } status_fields_t;

  // Write data seen raw or through the field layout of the target register
  typedef union packed {
    word_t           word;
    ctrl_fields_t    ctrl;
    trigger_fields_t trigger;
  } reg_word_u;

endpackage

//--- aes_reg_top.sv
`timescale 1ns/1ps
`include "aes_reg_params.svh"

module aes_reg_top (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,

  // APB slave
  input  logic                                          psel_i,
  input  logic                                          penable_i,
  input  logic                                          pwrite_i,
  input  logic [`AES_REG_APB_AW-1:0]                    paddr_i,
  input  aes_reg_pkg::word_t                            pwdata_i,
  output aes_reg_pkg::word_t                            prdata_o,
  output logic                                          pslverr_o,
  output logic                                          pready_o,

  // Key, IV and input data words
  output aes_reg_pkg::word_t [2*`AES_BANK_WORDS-1:0]    key_share0_o,
  output logic               [2*`AES_BANK_WORDS-1:0]    key_share0_qe_o,
  output aes_reg_pkg::word_t [2*`AES_BANK_WORDS-1:0]    key_share1_o,
  output logic               [2*`AES_BANK_WORDS-1:0]    key_share1_qe_o,
  output aes_reg_pkg::word_t [`AES_BANK_WORDS-1:0]      iv_o,
  output logic               [`AES_BANK_WORDS-1:0]      iv_qe_o,
  output aes_reg_pkg::word_t [`AES_BANK_WORDS-1:0]      data_in_o,
  output logic               [`AES_BANK_WORDS-1:0]      data_in_qe_o,

  // Output data and status from the engine
  input  aes_reg_pkg::word_t [`AES_BANK_WORDS-1:0]      data_out_i,
  output logic               [`AES_BANK_WORDS-1:0]      data_out_re_o,
  input  aes_reg_pkg::status_fields_t                   status_i,

  output aes_reg_pkg::ctrl_fields_t                     ctrl_o,
  output logic                                          ctrl_aux_o,

  output logic                                          trigger_start_o,
  input  logic                                          trigger_start_ack_i,
  output logic                                          trigger_key_iv_data_in_clear_o,
  input  logic                                          trigger_key_iv_data_in_clear_ack_i,
  output logic                                          trigger_data_out_clear_o,
  input  logic                                          trigger_data_out_clear_ack_i
);

  localparam int AW = `AES_REG_AW;

  aes_reg_pkg::word_t [`AES_NUM_BANKS-1:0][`AES_BANK_WORDS-1:0] bank_words;
  logic               [`AES_NUM_BANKS-1:0][`AES_BANK_WORDS-1:0] bank_qe;
  logic               [`AES_NUM_BANKS-1:0]                      bank_hit;

  aes_reg_bus_if reg_bus ();

  aes_apb_adapter u_apb_adapter (
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pslverr_o (pslverr_o),
    .pready_o  (pready_o),
    .bus       (reg_bus)
  );

  // Banks sit back to back from the first bank offset
  for (genvar b = 0; b < `AES_NUM_BANKS; b++) begin : g_bank
    aes_word_bank #(
      .BASE (AW'(`AES_BANK_BASE + 16 * b))
    ) u_bank (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .bus     (reg_bus),
      .words_o (bank_words[b]),
      .qe_o    (bank_qe[b]),
      .hit_o   (bank_hit[b])
    );
  end

  // Banks 0-1 key share 0, 2-3 key share 1, 4 IV, 5 input data
  assign key_share0_o    = {bank_words[1], bank_words[0]};
  assign key_share0_qe_o = {bank_qe[1], bank_qe[0]};
  assign key_share1_o    = {bank_words[3], bank_words[2]};
  assign key_share1_qe_o = {bank_qe[3], bank_qe[2]};
  assign iv_o            = bank_words[4];
  assign iv_qe_o         = bank_qe[4];
  assign data_in_o       = bank_words[5];
  assign data_in_qe_o    = bank_qe[5];

  aes_ctrl_readback u_ctrl_readback (
    .clk_i                              (clk_i),
    .rst_ni                             (rst_ni),
    .bus                                (reg_bus),
    .bank_hit_i                         (bank_hit),
    .data_out_i                         (data_out_i),
    .data_out_re_o                      (data_out_re_o),
    .status_i                           (status_i),
    .ctrl_o                             (ctrl_o),
    .ctrl_aux_o                         (ctrl_aux_o),
    .trigger_start_o                    (trigger_start_o),
    .trigger_start_ack_i                (trigger_start_ack_i),
    .trigger_key_iv_data_in_clear_o     (trigger_key_iv_data_in_clear_o),
    .trigger_key_iv_data_in_clear_ack_i (trigger_key_iv_data_in_clear_ack_i),
    .trigger_data_out_clear_o           (trigger_data_out_clear_o),
    .trigger_data_out_clear_ack_i       (trigger_data_out_clear_ack_i)
  );

endmodule

//--- aes_reg_trace.txt
# W addr data | R addr rdata pslverr | S status|dout idx value | A start|kiv|dout
# H name idx value strobe, with name one of ks0 ks1 iv din ctrl aux trig
H trig 0 6 0
H aux 0 1 0
W 18 11112222
H ks0 5 11112222 1
W 2c a5a5a5a5
H ks1 2 a5a5a5a5 1
W 48 0badcafe
H iv 1 0badcafe 1
W 60 deadbeef
H din 3 deadbeef 1
R 18 0 0
W 78 ffffffff
H ctrl 0 000087ff 0
R 78 000087ff 0
W 7c 0
H aux 0 0 0
W 80 0
W 7c 1
H aux 0 0 0
R 80 0 0
R 7c 0 0
W 84 1
H trig 0 7 0
H trig 0 7 0
A start
H trig 0 6 0
A dout
H trig 0 2 0
S status 0 15
R 88 15 0
S dout 2 12345678
R 6c 12345678 0
R 74 ffffffff 1
W 0 ffffffff
R 0 ffffffff 1
H ks0 5 11112222 0
H ctrl 0 000087ff 0

//--- aes_word_bank.sv
`timescale 1ns/1ps
`include "aes_reg_params.svh"

module aes_word_bank #(
  parameter logic [`AES_REG_AW-1:0] BASE = `AES_BANK_BASE
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,

  aes_reg_bus_if.bank                                   bus,

  output aes_reg_pkg::word_t [`AES_BANK_WORDS-1:0]      words_o,
  output logic               [`AES_BANK_WORDS-1:0]      qe_o,
  output logic                                          hit_o
);

  localparam int AW = `AES_REG_AW;

  logic               [`AES_BANK_WORDS-1:0] word_hit;
  logic               [`AES_BANK_WORDS-1:0] word_we;
  aes_reg_pkg::word_t [`AES_BANK_WORDS-1:0] words_q;
  logic               [`AES_BANK_WORDS-1:0] qe_q;

  // Exact word match, unaligned offsets miss
  always_comb begin
    for (int i = 0; i < `AES_BANK_WORDS; i++) begin
      word_hit[i] = (bus.addr == AW'(BASE + 4 * i));
    end
  end

  assign hit_o   = |word_hit;
  assign word_we = word_hit & {`AES_BANK_WORDS{bus.we}};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      words_q <= '0;
      qe_q    <= '0;
    end else begin
      // Strobe follows the write by one cycle, together with the new word
      qe_q <= word_we;
      for (int i = 0; i < `AES_BANK_WORDS; i++) begin
        if (word_we[i]) begin
          words_q[i] <= bus.wdata;
        end
      end
    end
  end

  assign words_o = words_q;
  assign qe_o    = qe_q;

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_aes_reg -o tb_aes_reg_sim

status=0
./obj_dir/tb_aes_reg_sim +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "=== FAIL ===" sim.log; then
  exit 1
fi

//--- tb_aes_reg.sv
`timescale 1ns/1ps
`include "aes_reg_params.svh"

module tb_aes_reg;

  localparam int RESET_CYCLES    = 5;
  localparam int CYCLES_PER_LINE = 20;

  logic                                       clk = 1'b0;
  logic                                       rst_n;
  logic                                       psel, penable, pwrite, pslverr, pready;
  logic [`AES_REG_APB_AW-1:0]                 paddr;
  aes_reg_pkg::word_t                         pwdata, prdata;
  aes_reg_pkg::word_t [2*`AES_BANK_WORDS-1:0] key_share0, key_share1;
  logic [2*`AES_BANK_WORDS-1:0]               key_share0_qe, key_share1_qe;
  aes_reg_pkg::word_t [`AES_BANK_WORDS-1:0]   iv, data_in, data_out;
  logic [`AES_BANK_WORDS-1:0]                 iv_qe, data_in_qe, data_out_re;
  aes_reg_pkg::status_fields_t                status;
  aes_reg_pkg::ctrl_fields_t                  ctrl;
  logic                                       ctrl_aux;
  logic                                       trig_start, trig_kiv, trig_dout;
  logic                                       trig_start_ack, trig_kiv_ack, trig_dout_ack;

  // Check requests towards the monitor
  logic               chk_valid, chk_flag, bad_line;
  logic [3:0]         chk_kind;
  logic [2:0]         chk_idx;
  aes_reg_pkg::word_t chk_exp;
  int                 bad_line_num;
  int                 value_errs, trace_errs;
  int                 file_errs = 0;
  int                 cycles = 0;
  int                 limit = 0;
  string              trace[$];

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("Timeout after %0d cycles, trace did not complete", cycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  aes_reg_top i_dut (
    .clk_i (clk), .rst_ni (rst_n),
    .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite), .paddr_i (paddr),
    .pwdata_i (pwdata), .prdata_o (prdata), .pslverr_o (pslverr), .pready_o (pready),
    .key_share0_o (key_share0), .key_share0_qe_o (key_share0_qe),
    .key_share1_o (key_share1), .key_share1_qe_o (key_share1_qe),
    .iv_o (iv), .iv_qe_o (iv_qe), .data_in_o (data_in), .data_in_qe_o (data_in_qe),
    .data_out_i (data_out), .data_out_re_o (data_out_re), .status_i (status),
    .ctrl_o (ctrl), .ctrl_aux_o (ctrl_aux),
    .trigger_start_o (trig_start), .trigger_start_ack_i (trig_start_ack),
    .trigger_key_iv_data_in_clear_o (trig_kiv),
    .trigger_key_iv_data_in_clear_ack_i (trig_kiv_ack),
    .trigger_data_out_clear_o (trig_dout), .trigger_data_out_clear_ack_i (trig_dout_ack)
  );

  tb_aes_reg_monitor i_mon (
    .clk_i (clk), .chk_valid_i (chk_valid), .chk_kind_i (chk_kind), .chk_idx_i (chk_idx),
    .chk_exp_i (chk_exp), .chk_flag_i (chk_flag),
    .bad_line_i (bad_line), .bad_line_num_i (bad_line_num),
    .paddr_i (paddr), .prdata_i (prdata), .pslverr_i (pslverr), .data_out_re_i (data_out_re),
    .key_share0_i (key_share0), .key_share0_qe_i (key_share0_qe),
    .key_share1_i (key_share1), .key_share1_qe_i (key_share1_qe),
    .iv_i (iv), .iv_qe_i (iv_qe), .data_in_i (data_in), .data_in_qe_i (data_in_qe),
    .ctrl_i (ctrl), .ctrl_aux_i (ctrl_aux), .trigger_i ({trig_dout, trig_kiv, trig_start}),
    .value_errs_o (value_errs), .trace_errs_o (trace_errs)
  );

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  // Monitor compares at the next rising edge
  task automatic check_at_edge(input logic [3:0] kind, input logic [2:0] idx,
                               input aes_reg_pkg::word_t exp, input logic flag);
    chk_kind  = kind;
    chk_idx   = idx;
    chk_exp   = exp;
    chk_flag  = flag;
    chk_valid = 1'b1;
    step();
    chk_valid = 1'b0;
  endtask

  // Mapped words are the banks and data output words, then ctrl up to status
  function automatic bit reg_mapped(input logic [`AES_REG_AW-1:0] addr);
    if (addr[1:0] != 2'b00) begin
      return 1'b0;
    end
    return (addr >= `AES_BANK_BASE && addr < `AES_DATA_OUT_OFFSET + 8'h10) ||
           (addr >= `AES_CTRL_OFFSET && addr <= `AES_STATUS_OFFSET);
  endfunction

  task automatic apb_write(input logic [31:0] addr, input aes_reg_pkg::word_t data);
    paddr  = addr[`AES_REG_APB_AW-1:0];
    pwdata = data;
    pwrite = 1'b1;
    psel   = 1'b1;
    step();
    penable = 1'b1;
    check_at_edge(4'd8, 3'd0, '0, !reg_mapped(addr[`AES_REG_AW-1:0]));
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [31:0] addr, input aes_reg_pkg::word_t exp,
                          input logic err);
    aes_reg_pkg::status_fields_t held;
    bit                          status_rd;
    status_rd = (addr[`AES_REG_AW-1:0] == `AES_STATUS_OFFSET);
    held      = status;
    paddr  = addr[`AES_REG_APB_AW-1:0];
    pwrite = 1'b0;
    psel   = 1'b1;
    step();
    penable = 1'b1;
    // Status is sampled, so a change during the access must not reach PRDATA
    if (status_rd) begin
      status = ~held;
    end
    check_at_edge(4'd0, 3'd0, exp, err);
    status  = held;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  function automatic logic [3:0] hw_kind(input string name);
    case (name)
      "ks0":   return 4'd1;
      "ks1":   return 4'd2;
      "iv":    return 4'd3;
      "din":   return 4'd4;
      "ctrl":  return 4'd5;
      "aux":   return 4'd6;
      "trig":  return 4'd7;
      default: return 4'd15;
    endcase
  endfunction

  task automatic run_line(input string line, input int num);
    string       op;
    string       name;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [3:0]  kind;
    int          n;
    bit          ok;
    if (line.len() < 2 || line.getc(0) == "#") begin
      return;
    end
    n  = $sscanf(line, "%s", op);
    ok = 1'b0;
    case (op)
      "W": begin
        n  = $sscanf(line, "%s %h %h", op, a, b);
        ok = (n == 3);
        if (ok) begin
          apb_write(a, b);
        end
      end
      "R": begin
        n  = $sscanf(line, "%s %h %h %h", op, a, b, c);
        ok = (n == 4);
        if (ok) begin
          apb_read(a, b, c[0]);
        end
      end
      "S": begin
        n  = $sscanf(line, "%s %s %h %h", op, name, a, b);
        ok = (n == 4) && (name == "status" || name == "dout");
        if (ok) begin
          if (name == "status") begin
            status = b;
          end else begin
            data_out[a[1:0]] = b;
          end
          step();
        end
      end
      "A": begin
        n  = $sscanf(line, "%s %s", op, name);
        ok = (n == 2) && (name == "start" || name == "kiv" || name == "dout");
        if (ok) begin
          trig_start_ack = (name == "start");
          trig_kiv_ack   = (name == "kiv");
          trig_dout_ack  = (name == "dout");
          step();
          trig_start_ack = 1'b0;
          trig_kiv_ack   = 1'b0;
          trig_dout_ack  = 1'b0;
        end
      end
      "H": begin
        n    = $sscanf(line, "%s %s %h %h %h", op, name, a, b, c);
        kind = hw_kind(name);
        ok   = (n == 5) && (kind != 4'd15);
        if (ok) begin
          check_at_edge(kind, a[2:0], b, c[0]);
        end
      end
      default: ok = 1'b0;
    endcase
    if (!ok) begin
      bad_line     = 1'b1;
      bad_line_num = num;
      step();
      bad_line = 1'b0;
    end
  endtask

  initial begin
    int    fd;
    int    total;
    string line;
    rst_n          = 1'b0;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    paddr          = '0;
    pwdata         = '0;
    status         = '0;
    data_out       = '0;
    trig_start_ack = 1'b0;
    trig_kiv_ack   = 1'b0;
    trig_dout_ack  = 1'b0;
    chk_valid      = 1'b0;
    chk_kind       = '0;
    chk_idx        = '0;
    chk_exp        = '0;
    chk_flag       = 1'b0;
    bad_line       = 1'b0;
    bad_line_num   = 0;
    fd = $fopen("aes_reg_trace.txt", "r");
    if (fd == 0) begin
      $display("Trace file aes_reg_trace.txt could not be opened");
      file_errs++;
    end else begin
      while ($fgets(line, fd) > 0) begin
        trace.push_back(line);
      end
      $fclose(fd);
    end
    limit = CYCLES_PER_LINE * trace.size() + RESET_CYCLES;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    foreach (trace[i]) begin
      run_line(trace[i], i + 1);
    end
    step();
    total = value_errs + trace_errs + file_errs + i_dut.u_checker.fail_cnt;
    $display("Errors: %0d value, %0d trace, %0d assertion", value_errs,
             trace_errs + file_errs, i_dut.u_checker.fail_cnt);
    if (total == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- tb_aes_reg_checker.sv
`timescale 1ns/1ps
`include "aes_reg_params.svh"

module tb_aes_reg_checker (
  input logic                       clk_i,
  input logic                       rst_ni,
  input logic                       psel_i,
  input logic                       penable_i,
  input logic                       pwrite_i,
  input logic                       pready_i,
  input logic                       pslverr_i,
  input logic [`AES_BANK_WORDS-1:0] data_out_re_i,
  input logic                       trigger_start_i,
  input logic                       trigger_start_ack_i
);

  int fail_cnt = 0;

  pready_high: assert property (@(posedge clk_i) disable iff (!rst_ni) pready_i)
    else begin
      $error("PREADY went low");
      fail_cnt++;
    end

  // Error response belongs to the access phase only
  slverr_in_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pslverr_i |-> (psel_i && penable_i))
    else begin
      $error("PSLVERR high outside an access cycle");
      fail_cnt++;
    end

  re_in_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|data_out_re_i) |-> (psel_i && penable_i && !pwrite_i))
    else begin
      $error("Data output read strobe outside a read access");
      fail_cnt++;
    end

  start_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(trigger_start_i) |-> $past(trigger_start_ack_i))
    else begin
      $error("Start trigger dropped without an acknowledge");
      fail_cnt++;
    end

endmodule

bind aes_reg_top tb_aes_reg_checker u_checker (
  .clk_i               (clk_i),
  .rst_ni              (rst_ni),
  .psel_i              (psel_i),
  .penable_i           (penable_i),
  .pwrite_i            (pwrite_i),
  .pready_i            (pready_o),
  .pslverr_i           (pslverr_o),
  .data_out_re_i       (data_out_re_o),
  .trigger_start_i     (trigger_start_o),
  .trigger_start_ack_i (trigger_start_ack_i)
);

//--- tb_aes_reg_monitor.sv
`timescale 1ns/1ps
`include "aes_reg_params.svh"

module tb_aes_reg_monitor (
  input  logic                                       clk_i,
  // Check requests from the trace player
  input  logic                                       chk_valid_i,
  input  logic [3:0]                                 chk_kind_i,
  input  logic [2:0]                                 chk_idx_i,
  input  aes_reg_pkg::word_t                         chk_exp_i,
  input  logic                                       chk_flag_i,
  input  logic                                       bad_line_i,
  input  int                                         bad_line_num_i,
  // Observed DUT ports
  input  logic [`AES_REG_APB_AW-1:0]                 paddr_i,
  input  aes_reg_pkg::word_t                         prdata_i,
  input  logic                                       pslverr_i,
  input  logic [`AES_BANK_WORDS-1:0]                 data_out_re_i,
  input  aes_reg_pkg::word_t [2*`AES_BANK_WORDS-1:0] key_share0_i,
  input  logic [2*`AES_BANK_WORDS-1:0]               key_share0_qe_i,
  input  aes_reg_pkg::word_t [2*`AES_BANK_WORDS-1:0] key_share1_i,
  input  logic [2*`AES_BANK_WORDS-1:0]               key_share1_qe_i,
  input  aes_reg_pkg::word_t [`AES_BANK_WORDS-1:0]   iv_i,
  input  logic [`AES_BANK_WORDS-1:0]                 iv_qe_i,
  input  aes_reg_pkg::word_t [`AES_BANK_WORDS-1:0]   data_in_i,
  input  logic [`AES_BANK_WORDS-1:0]                 data_in_qe_i,
  input  aes_reg_pkg::word_t                         ctrl_i,
  input  logic                                       ctrl_aux_i,
  input  logic [2:0]                                 trigger_i,
  output int                                         value_errs_o,
  output int                                         trace_errs_o
);

  int                         value_errs = 0;
  int                         trace_errs = 0;
  logic [`AES_REG_AW-1:0]     rel;
  logic [`AES_BANK_WORDS-1:0] exp_re;

  task automatic compare(input string name, input int idx, input aes_reg_pkg::word_t exp,
                         input aes_reg_pkg::word_t act);
    if (act !== exp) begin
      $display("FAILED %s[%0d] expected 0x%08h actual 0x%08h", name, idx, exp, act);
      value_errs++;
    end
  endtask

  always @(posedge clk_i) begin
    if (bad_line_i) begin
      $display("Trace line %0d could not be parsed", bad_line_num_i);
      trace_errs++;
    end
    if (chk_valid_i) begin
      case (chk_kind_i)
        4'd0: begin
          // Read strobe expected only for the four data output words
          rel    = paddr_i[`AES_REG_AW-1:0] - `AES_DATA_OUT_OFFSET;
          exp_re = '0;
          if (rel < 8'h10 && rel[1:0] == 2'b00) begin
            exp_re[rel[3:2]] = 1'b1;
          end
          compare("prdata_o", 0, chk_exp_i, prdata_i);
          compare("pslverr_o", 0, 32'(chk_flag_i), 32'(pslverr_i));
          compare("data_out_re_o", 0, 32'(exp_re), 32'(data_out_re_i));
        end
        4'd1: begin
          compare("key_share0_o", chk_idx_i, chk_exp_i, key_share0_i[chk_idx_i]);
          compare("key_share0_qe_o", chk_idx_i, 32'(chk_flag_i), 32'(key_share0_qe_i[chk_idx_i]));
        end
        4'd2: begin
          compare("key_share1_o", chk_idx_i, chk_exp_i, key_share1_i[chk_idx_i]);
          compare("key_share1_qe_o", chk_idx_i, 32'(chk_flag_i), 32'(key_share1_qe_i[chk_idx_i]));
        end
        4'd3: begin
          compare("iv_o", chk_idx_i, chk_exp_i, iv_i[chk_idx_i[1:0]]);
          compare("iv_qe_o", chk_idx_i, 32'(chk_flag_i), 32'(iv_qe_i[chk_idx_i[1:0]]));
        end
        4'd4: begin
          compare("data_in_o", chk_idx_i, chk_exp_i, data_in_i[chk_idx_i[1:0]]);
          compare("data_in_qe_o", chk_idx_i, 32'(chk_flag_i), 32'(data_in_qe_i[chk_idx_i[1:0]]));
        end
        4'd5: compare("ctrl_o", 0, chk_exp_i, ctrl_i);
        4'd6: compare("ctrl_aux_o", 0, chk_exp_i, 32'(ctrl_aux_i));
        // Order is {data_out_clear, key_iv_data_in_clear, start}
        4'd7: compare("trigger_o", 0, chk_exp_i, 32'(trigger_i));
        // Error response of a write access
        4'd8: compare("pslverr_o", 0, 32'(chk_flag_i), 32'(pslverr_i));
        default: begin
          $display("Check request with unknown kind %0d", chk_kind_i);
          trace_errs++;
        end
      endcase
    end
  end

  assign value_errs_o = value_errs;
  assign trace_errs_o = trace_errs;

endmodule

//--- verilog.f
+incdir+.
aes_reg_pkg.sv
aes_reg_bus_if.sv
aes_apb_adapter.sv
aes_word_bank.sv
aes_ctrl_readback.sv
aes_reg_top.sv
tb_aes_reg_checker.sv
tb_aes_reg_monitor.sv
tb_aes_reg.sv
